// ==== hdl/decode_wb.sv ====
`timescale 1ns/10ps

module decode_wb (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             issue,
  input  y86_pkg::icode_e  icode,
  input  logic [3:0]       ifun,
  input  y86_pkg::reg_id_t ra,
  input  y86_pkg::reg_id_t rb,
  input  y86_pkg::word_t   valc,
  input  y86_pkg::reg_id_t dbg_addr,
  output y86_pkg::word_t   dbg_data,
  exe_if.src               exe,
  wb_if.sink               wb
);

  y86_pkg::word_t   reg_mem [0:y86_pkg::NUM_REGS-1];
  y86_pkg::reg_id_t src_a;
  y86_pkg::reg_id_t src_b;

  always_comb
  begin
    src_a     = y86_pkg::R_NONE;
    src_b     = y86_pkg::R_NONE;
    exe.dst_e = y86_pkg::R_NONE;
    exe.dst_m = y86_pkg::R_NONE;
    case (icode)
      y86_pkg::I_CMOV:
      begin
        src_a     = ra;
        exe.dst_e = rb;
      end
      y86_pkg::I_IRMOV:
        exe.dst_e = rb;
      y86_pkg::I_RMMOV:
      begin
        src_a = ra;
        src_b = rb;
      end
      y86_pkg::I_MRMOV:
      begin
        src_b     = rb;
        exe.dst_m = ra;
      end
      y86_pkg::I_OPQ:
      begin
        src_a     = ra;
        src_b     = rb;
        exe.dst_e = rb;
      end
      y86_pkg::I_PUSH:
      begin
        src_a     = ra;
        src_b     = y86_pkg::R_RSP;
        exe.dst_e = y86_pkg::R_RSP;
      end
      y86_pkg::I_POP:
      begin
        src_a     = y86_pkg::R_RSP; // old rsp is the load address
        src_b     = y86_pkg::R_RSP;
        exe.dst_e = y86_pkg::R_RSP;
        exe.dst_m = ra;
      end
      default:
        src_a = y86_pkg::R_NONE; // halt, nop
    endcase
  end

  // read with write-through, dst_m has priority like the write order
  always_comb
  begin
    exe.val_a = '0;
    exe.val_b = '0;
    if (src_a != y86_pkg::R_NONE)
    begin
      if (wb.valid && wb.dst_m == src_a)
        exe.val_a = wb.val_m;
      else if (wb.valid && wb.dst_e == src_a)
        exe.val_a = wb.val_e;
      else
        exe.val_a = reg_mem[src_a];
    end
    if (src_b != y86_pkg::R_NONE)
    begin
      if (wb.valid && wb.dst_m == src_b)
        exe.val_b = wb.val_m;
      else if (wb.valid && wb.dst_e == src_b)
        exe.val_b = wb.val_e;
      else
        exe.val_b = reg_mem[src_b];
    end
  end

  assign exe.valid = issue;
  assign exe.icode = icode;
  assign exe.ifun  = ifun;
  assign exe.val_c = valc;

  assign dbg_data = (dbg_addr == y86_pkg::R_NONE) ? '0 : reg_mem[dbg_addr];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < y86_pkg::NUM_REGS; i++)
        reg_mem[i] <= y86_pkg::word_t'(i); // each reg holds its index
    end
    else if (wb.valid)
    begin
      if (wb.dst_e != y86_pkg::R_NONE)
        reg_mem[wb.dst_e] <= wb.val_e;
      if (wb.dst_m != y86_pkg::R_NONE)
        reg_mem[wb.dst_m] <= wb.val_m; // later write wins
    end
  end

  a_icode_supported: assert property (@(posedge clk) disable iff (!arst_n)
    issue |-> icode inside {y86_pkg::I_HALT, y86_pkg::I_NOP, y86_pkg::I_CMOV,
                            y86_pkg::I_IRMOV, y86_pkg::I_RMMOV, y86_pkg::I_MRMOV,
                            y86_pkg::I_OPQ, y86_pkg::I_PUSH, y86_pkg::I_POP});

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/10ps

module execute_unit (
  input  logic clk,
  input  logic arst_n,
  exe_if.sink  exe,
  mem_if.src   mem
);

  localparam int MSB = y86_pkg::WORD_W - 1;

  logic             d_valid;
  y86_pkg::icode_e  d_icode;
  logic [3:0]       d_ifun;
  y86_pkg::word_t   d_val_a;
  y86_pkg::word_t   d_val_b;
  y86_pkg::word_t   d_val_c;
  y86_pkg::reg_id_t d_dst_e;
  y86_pkg::reg_id_t d_dst_m;
  logic             zf;
  logic             sf;
  logic             of;
  y86_pkg::word_t   alu_out;
  logic             alu_of;
  logic             cnd;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      d_valid <= 1'b0;
    else
      d_valid <= exe.valid;
  end

  always_ff @(posedge clk)
  begin
    if (exe.valid)
    begin
      d_icode <= exe.icode;
      d_ifun  <= exe.ifun;
      d_val_a <= exe.val_a;
      d_val_b <= exe.val_b;
      d_val_c <= exe.val_c;
      d_dst_e <= exe.dst_e;
      d_dst_m <= exe.dst_m;
    end
  end

  always_comb
  begin
    alu_of = 1'b0;
    case (y86_pkg::alu_fn_e'(d_ifun))
      y86_pkg::ALU_ADD:
      begin
        alu_out = d_val_b + d_val_a;
        alu_of  = (d_val_a[MSB] == d_val_b[MSB]) && (alu_out[MSB] != d_val_b[MSB]);
      end
      y86_pkg::ALU_SUB:
      begin
        alu_out = d_val_b - d_val_a; // valB - valA
        alu_of  = (d_val_a[MSB] != d_val_b[MSB]) && (alu_out[MSB] != d_val_b[MSB]);
      end
      y86_pkg::ALU_AND:
        alu_out = d_val_b & d_val_a;
      y86_pkg::ALU_XOR:
        alu_out = d_val_b ^ d_val_a;
      default:
        alu_out = '0;
    endcase
  end

  always_comb
  begin
    case (y86_pkg::cmov_fn_e'(d_ifun))
      y86_pkg::C_ALWAYS: cnd = 1'b1;
      y86_pkg::C_LE:     cnd = (sf ^ of) | zf;
      y86_pkg::C_L:      cnd = sf ^ of;
      y86_pkg::C_E:      cnd = zf;
      y86_pkg::C_NE:     cnd = !zf;
      y86_pkg::C_GE:     cnd = !(sf ^ of);
      y86_pkg::C_G:      cnd = !(sf ^ of) && !zf;
      default:           cnd = 1'b0;
    endcase
  end

  always_comb
  begin
    case (d_icode)
      y86_pkg::I_CMOV:  mem.val_e = d_val_a;
      y86_pkg::I_IRMOV: mem.val_e = d_val_c;
      y86_pkg::I_RMMOV,
      y86_pkg::I_MRMOV: mem.val_e = d_val_b + d_val_c; // effective address
      y86_pkg::I_OPQ:   mem.val_e = alu_out;
      y86_pkg::I_PUSH:  mem.val_e = d_val_b - 64'd8;
      y86_pkg::I_POP:   mem.val_e = d_val_b + 64'd8;
      default:          mem.val_e = '0;
    endcase
  end

  assign mem.valid = d_valid;
  assign mem.icode = d_icode;
  assign mem.val_a = d_val_a;
  assign mem.dst_e = (d_icode == y86_pkg::I_CMOV && !cnd) ? y86_pkg::R_NONE : d_dst_e;
  assign mem.dst_m = d_dst_m;

  // codes move only on OPq, cmov reads them as they were before
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      zf <= 1'b1;
      sf <= 1'b0;
      of <= 1'b0;
    end
    else if (d_valid && d_icode == y86_pkg::I_OPQ)
    begin
      zf <= (alu_out == '0);
      sf <= alu_out[MSB];
      of <= alu_of;
    end
  end

  a_opq_ifun: assert property (@(posedge clk) disable iff (!arst_n)
    d_valid && d_icode == y86_pkg::I_OPQ |-> d_ifun < 4'd4);
  a_cmov_ifun: assert property (@(posedge clk) disable iff (!arst_n)
    d_valid && d_icode == y86_pkg::I_CMOV |-> d_ifun < 4'd7);

endmodule

// ==== hdl/mem_wb_unit.sv ====
`timescale 1ns/10ps

module mem_wb_unit (
  input  logic clk,
  input  logic arst_n,
  mem_if.sink  mem,
  wb_if.src    wb
);

  localparam int AW = y86_pkg::DMEM_AW;

  logic             m_valid;
  y86_pkg::icode_e  m_icode;
  y86_pkg::word_t   m_val_e;
  y86_pkg::word_t   m_val_a;
  y86_pkg::reg_id_t m_dst_e;
  y86_pkg::reg_id_t m_dst_m;
  y86_pkg::word_t   dmem [0:y86_pkg::DMEM_WORDS-1];
  logic [AW-1:0]    rd_idx;
  logic [AW-1:0]    wr_idx;
  logic             st_en;

  always_ff @(posedge clk)
  begin
    if (mem.valid)
    begin
      m_icode <= mem.icode;
      m_val_e <= mem.val_e;
      m_val_a <= mem.val_a;
      m_dst_e <= mem.dst_e;
      m_dst_m <= mem.dst_m;
    end
  end

  // word index from byte address, wraps at 128 bytes
  assign wr_idx = m_val_e[AW+2:3];
  assign rd_idx = (m_icode == y86_pkg::I_POP) ? m_val_a[AW+2:3] : m_val_e[AW+2:3];
  assign st_en  = m_valid && (m_icode == y86_pkg::I_RMMOV || m_icode == y86_pkg::I_PUSH);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      m_valid <= 1'b0;
      for (int i = 0; i < y86_pkg::DMEM_WORDS; i++)
        dmem[i] <= '0;
    end
    else
    begin
      m_valid <= mem.valid;
      if (st_en)
        dmem[wr_idx] <= m_val_a; // push stores at new rsp
    end
  end

  assign wb.valid = m_valid;
  assign wb.dst_e = m_dst_e;
  assign wb.val_e = m_val_e;
  assign wb.dst_m = m_dst_m;
  assign wb.val_m = dmem[rd_idx];

  // a load must land somewhere
  a_load_has_dst: assert property (@(posedge clk) disable iff (!arst_n)
    wb.valid && (m_icode inside {y86_pkg::I_MRMOV, y86_pkg::I_POP})
      |-> !(wb.dst_e == y86_pkg::R_NONE && wb.dst_m == y86_pkg::R_NONE));

endmodule

// ==== hdl/y86_core.sv ====
`timescale 1ns/10ps

module y86_core (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             issue,
  input  logic [3:0]       icode,
  input  logic [3:0]       ifun,
  input  y86_pkg::reg_id_t ra,
  input  y86_pkg::reg_id_t rb,
  input  y86_pkg::word_t   valc,
  input  y86_pkg::reg_id_t dbg_addr,
  output y86_pkg::word_t   dbg_data,
  output logic             wb_valid,
  output y86_pkg::reg_id_t wb_dst_e,
  output y86_pkg::word_t   wb_val_e,
  output y86_pkg::reg_id_t wb_dst_m,
  output y86_pkg::word_t   wb_val_m
);

  y86_pkg::icode_e icode_enum;

  exe_if i_exe_if ();
  mem_if i_mem_if ();
  wb_if  i_wb_if ();

  assign icode_enum = y86_pkg::icode_e'(icode); // raw issuer code to enum

  decode_wb i_decode_wb (
    .clk      (clk),
    .arst_n   (arst_n),
    .issue    (issue),
    .icode    (icode_enum),
    .ifun     (ifun),
    .ra       (ra),
    .rb       (rb),
    .valc     (valc),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data),
    .exe      (i_exe_if.src),
    .wb       (i_wb_if.sink)
  );

  execute_unit i_execute_unit (
    .clk    (clk),
    .arst_n (arst_n),
    .exe    (i_exe_if.sink),
    .mem    (i_mem_if.src)
  );

  mem_wb_unit i_mem_wb_unit (
    .clk    (clk),
    .arst_n (arst_n),
    .mem    (i_mem_if.sink),
    .wb     (i_wb_if.src)
  );

  assign wb_valid = i_wb_if.valid;
  assign wb_dst_e = i_wb_if.dst_e;
  assign wb_val_e = i_wb_if.val_e;
  assign wb_dst_m = i_wb_if.dst_m;
  assign wb_val_m = i_wb_if.val_m;

endmodule

// ==== hdl/y86_ifs.sv ====
`timescale 1ns/10ps

// decoded instruction with operands, into execute
interface exe_if;
  logic             valid;
  y86_pkg::icode_e  icode;
  logic [3:0]       ifun;
  y86_pkg::word_t   val_a;
  y86_pkg::word_t   val_b;
  y86_pkg::word_t   val_c;
  y86_pkg::reg_id_t dst_e;
  y86_pkg::reg_id_t dst_m;

  modport src (output valid, icode, ifun, val_a, val_b, val_c, dst_e, dst_m);
  modport sink (input valid, icode, ifun, val_a, val_b, val_c, dst_e, dst_m);
endinterface

interface mem_if;
  logic             valid;
  y86_pkg::icode_e  icode;
  y86_pkg::word_t   val_e;
  y86_pkg::word_t   val_a;
  y86_pkg::reg_id_t dst_e; // R_NONE for a failed cmov
  y86_pkg::reg_id_t dst_m;

  modport src (output valid, icode, val_e, val_a, dst_e, dst_m);
  modport sink (input valid, icode, val_e, val_a, dst_e, dst_m);
endinterface

// writeback bus, one pulse per instruction
interface wb_if;
  logic             valid;
  y86_pkg::reg_id_t dst_e;
  y86_pkg::word_t   val_e;
  y86_pkg::reg_id_t dst_m;
  y86_pkg::word_t   val_m;

  modport src (output valid, dst_e, val_e, dst_m, val_m);
  modport sink (input valid, dst_e, val_e, dst_m, val_m);
endinterface

// ==== hdl/y86_pkg.sv ====
package y86_pkg;

  localparam int WORD_W     = 64;
  localparam int NUM_REGS   = 15;
  localparam int DMEM_WORDS = 16;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [3:0]        reg_id_t;

  localparam reg_id_t R_RSP  = 4'd4;
  localparam reg_id_t R_NONE = 4'd15; // no register

  typedef enum logic [3:0] {
    I_HALT  = 4'h0,
    I_NOP   = 4'h1,
    I_CMOV  = 4'h2,
    I_IRMOV = 4'h3,
    I_RMMOV = 4'h4,
    I_MRMOV = 4'h5,
    I_OPQ   = 4'h6,
    I_PUSH  = 4'ha,
    I_POP   = 4'hb
  } icode_e;

  typedef enum logic [3:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_XOR = 4'h3
  } alu_fn_e;

  typedef enum logic [3:0] {
    C_ALWAYS = 4'h0, // also rrmovq
    C_LE     = 4'h1,
    C_L      = 4'h2,
    C_E      = 4'h3,
    C_NE     = 4'h4,
    C_GE     = 4'h5,
    C_G      = 4'h6
  } cmov_fn_e;

endpackage

// ==== tb/y86_core_tb.sv ====
`timescale 1ns/10ps

module y86_core_tb;

  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_CYCLES = 3;

  typedef struct packed {
    logic [3:0]  test;
    logic        iss;
    logic [3:0]  icode;
    logic [3:0]  ifun;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [63:0] valc;
    logic [1:0]  rnd; // 0 fixed, 1 fresh random, 2 reuse last random, 3 last random plus 128
  } row_t;

  typedef struct packed {
    logic [31:0] due;
    logic        chk_e;
    logic [3:0]  dst_e;
    logic [63:0] val_e;
    logic [3:0]  dst_m;
    logic [63:0] val_m;
  } wb_exp_t;

  logic        clk;
  logic        arst_n;
  logic        issue;
  logic [3:0]  icode;
  logic [3:0]  ifun;
  logic [3:0]  ra;
  logic [3:0]  rb;
  logic [63:0] valc;
  logic [3:0]  dbg_addr;
  logic [63:0] dbg_data;
  logic        wb_valid;
  logic [3:0]  wb_dst_e;
  logic [63:0] wb_val_e;
  logic [3:0]  wb_dst_m;
  logic [63:0] wb_val_m;

  row_t        rows[$];
  wb_exp_t     exp_q[$];
  logic [63:0] m_reg [0:15];
  logic [63:0] m_mem [0:15];
  logic        m_zf;
  logic        m_sf;
  logic        m_of;
  logic [15:0] lfsr;
  logic [63:0] last_rnd;
  int          cyc;
  int          tests;
  int          checks;
  int          errors;
  bit          table_built = 1'b0;

  y86_core i_y86_core (
    .clk      (clk),
    .arst_n   (arst_n),
    .issue    (issue),
    .icode    (icode),
    .ifun     (ifun),
    .ra       (ra),
    .rb       (rb),
    .valc     (valc),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data),
    .wb_valid (wb_valid),
    .wb_dst_e (wb_dst_e),
    .wb_val_e (wb_val_e),
    .wb_dst_m (wb_dst_m),
    .wb_val_m (wb_val_m)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_random(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[62:0], lfsr[0]}; // one step per bit
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic logic cond_true(input logic [3:0] fn);
    logic lt;
    lt = m_sf ^ m_of;
    case (fn)
      4'h0: return 1'b1;
      4'h1: return lt | m_zf;
      4'h2: return lt;
      4'h3: return m_zf;
      4'h4: return !m_zf;
      4'h5: return !lt;
      4'h6: return !lt && !m_zf;
      default: return 1'b0;
    endcase
  endfunction

  function automatic int mem_idx(input logic [63:0] addr);
    return int'((addr >> 3) % y86_pkg::DMEM_WORDS);
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "reset";
      2: return "alu";
      3: return "cmov";
      4: return "memory";
      5: return "stack";
      6: return "back_to_back";
      default: return "unknown";
    endcase
  endfunction

  task automatic model_exec(input row_t r, output wb_exp_t e);
    logic [63:0]        va;
    logic [63:0]        vb;
    logic [63:0]        rsp;
    logic signed [64:0] wide;
    va = m_reg[r.ra];
    vb = m_reg[r.rb];
    rsp = m_reg[y86_pkg::R_RSP];
    e = '0;
    e.due = cyc + 2;
    e.chk_e = 1'b1;
    e.dst_e = y86_pkg::R_NONE;
    e.dst_m = y86_pkg::R_NONE;
    case (r.icode)
      y86_pkg::I_CMOV:
      begin
        e.val_e = va;
        if (cond_true(r.ifun))
          e.dst_e = r.rb;
      end
      y86_pkg::I_IRMOV:
      begin
        e.val_e = r.valc;
        e.dst_e = r.rb;
      end
      y86_pkg::I_RMMOV:
      begin
        e.val_e = vb + r.valc;
        m_mem[mem_idx(e.val_e)] = va;
      end
      y86_pkg::I_MRMOV:
      begin
        e.val_e = vb + r.valc;
        e.val_m = m_mem[mem_idx(e.val_e)];
        e.dst_m = r.ra;
      end
      y86_pkg::I_OPQ:
      begin
        wide = (r.ifun == 4'h1) ? $signed({vb[63], vb}) - $signed({va[63], va})
                                : $signed({vb[63], vb}) + $signed({va[63], va});
        case (r.ifun)
          4'h2: e.val_e = vb & va;
          4'h3: e.val_e = vb ^ va;
          default: e.val_e = wide[63:0];
        endcase
        m_zf = (e.val_e == 64'h0);
        m_sf = e.val_e[63];
        m_of = (r.ifun < 4'h2) && (wide[64] != wide[63]); // does not fit in 64 bits
        e.dst_e = r.rb;
      end
      y86_pkg::I_PUSH:
      begin
        e.val_e = rsp - 64'd8;
        m_mem[mem_idx(e.val_e)] = va;
        e.dst_e = y86_pkg::R_RSP;
      end
      y86_pkg::I_POP:
      begin
        e.val_e = rsp + 64'd8;
        e.val_m = m_mem[mem_idx(rsp)];
        e.dst_e = y86_pkg::R_RSP;
        e.dst_m = r.ra;
      end
      default:
        e.chk_e = 1'b0; // nop, halt
    endcase
    if (e.dst_e != y86_pkg::R_NONE)
      m_reg[e.dst_e] = e.val_e;
    if (e.dst_m != y86_pkg::R_NONE)
      m_reg[e.dst_m] = e.val_m;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_wb();
    wb_exp_t e;
    checks++;
    if (exp_q.size() > 0 && exp_q[0].due == cyc)
    begin
      e = exp_q.pop_front();
      assert (wb_valid === 1'b1)
      else
      begin
        errors++;
        $display("no writeback pulse two cycles after issue, cycle %0d", cyc);
      end
      check_val("wb_dst_e", wb_dst_e, e.dst_e);
      if (e.chk_e)
        check_val("wb_val_e", wb_val_e, e.val_e);
      check_val("wb_dst_m", wb_dst_m, e.dst_m);
      if (e.dst_m != y86_pkg::R_NONE)
        check_val("wb_val_m", wb_val_m, e.val_m);
    end
    else
    begin
      assert (wb_valid !== 1'b1)
      else
      begin
        errors++;
        $display("writeback pulse with no instruction due, cycle %0d", cyc);
      end
    end
  endtask

  task automatic step(input row_t r);
    wb_exp_t e;
    @(negedge clk);
    cyc++;
    check_wb();
    if (r.rnd == 2'd1)
      draw_random(24, last_rnd);
    if (r.rnd == 2'd3)
      r.valc = last_rnd + 64'd128; // same word after the wrap
    else if (r.rnd != 2'd0)
      r.valc = last_rnd;
    issue = r.iss;
    icode = r.icode;
    ifun = r.ifun;
    ra = r.ra;
    rb = r.rb;
    valc = r.valc;
    if (r.iss)
    begin
      model_exec(r, e);
      exp_q.push_back(e);
    end
  endtask

  task automatic read_back();
    for (int i = 0; i < y86_pkg::NUM_REGS; i++)
    begin
      @(negedge clk);
      dbg_addr = 4'(i);
      @(posedge clk);
      check_val($sformatf("dbg_data r%0d", i), dbg_data, m_reg[i]);
    end
  endtask

  task automatic report_test(input int t, input int err_start);
    tests++;
    if (errors == err_start)
      $display("test %0d %s: ok", t, test_name(t));
    else
      $display("test %0d %s: %0d errors", t, test_name(t), errors - err_start);
  endtask

  task automatic add_row(input logic [3:0] t, input logic [3:0] ic, input logic [3:0] fn,
                         input logic [3:0] a, input logic [3:0] b, input logic [63:0] c,
                         input logic [1:0] rnd);
    rows.push_back({t, 1'b1, ic, fn, a, b, c, rnd});
  endtask

  task automatic idle_row(input logic [3:0] t);
    rows.push_back({t, 1'b0, 4'h1, 4'h0, 4'hf, 4'hf, 64'h0, 2'd0});
  endtask

  // opq sets the codes, then one cmov per condition into r8..r14
  task automatic cmov_group(input logic [3:0] fn, input logic [3:0] a, input logic [3:0] b);
    add_row(4'd3, y86_pkg::I_OPQ, fn, a, b, 64'h0, 2'd0);
    idle_row(4'd3);
    for (int c = 0; c < 7; c++)
      add_row(4'd3, y86_pkg::I_CMOV, 4'(c), b, 4'(8 + c), 64'h0, 2'd0);
  endtask

  task automatic build_table();
    add_row(4'd2, y86_pkg::I_IRMOV, 4'h0, 4'hf, 4'd1, 64'h7fff_ffff_ffff_ffff, 2'd0);
    add_row(4'd2, y86_pkg::I_IRMOV, 4'h0, 4'hf, 4'd2, 64'd5, 2'd0);
    idle_row(4'd2);
    add_row(4'd2, y86_pkg::I_OPQ, 4'h0, 4'd2, 4'd1, 64'h0, 2'd0); // signed overflow
    add_row(4'd2, y86_pkg::I_OPQ, 4'h1, 4'd2, 4'd3, 64'h0, 2'd0);
    add_row(4'd2, y86_pkg::I_OPQ, 4'h2, 4'd1, 4'd6, 64'h0, 2'd0);
    add_row(4'd2, y86_pkg::I_OPQ, 4'h3, 4'd7, 4'd7, 64'h0, 2'd0);
    cmov_group(4'h3, 4'd3, 4'd3); // zero
    cmov_group(4'h1, 4'd2, 4'd0); // negative
    cmov_group(4'h0, 4'd2, 4'd5); // positive
    add_row(4'd4, y86_pkg::I_IRMOV, 4'h0, 4'hf, 4'd8, 64'h0, 2'd1);
    idle_row(4'd4);
    add_row(4'd4, y86_pkg::I_RMMOV, 4'h0, 4'd8, 4'd2, 64'h0, 2'd1);
    add_row(4'd4, y86_pkg::I_MRMOV, 4'h0, 4'd10, 4'd2, 64'h0, 2'd2);
    add_row(4'd4, y86_pkg::I_IRMOV, 4'h0, 4'hf, 4'd11, 64'h0, 2'd1);
    idle_row(4'd4);
    add_row(4'd4, y86_pkg::I_RMMOV, 4'h0, 4'd11, 4'd6, 64'h0, 2'd1);
    add_row(4'd4, y86_pkg::I_MRMOV, 4'h0, 4'd12, 4'd6, 64'h0, 2'd3);
    add_row(4'd5, y86_pkg::I_IRMOV, 4'h0, 4'hf, 4'd4, 64'h40, 2'd0);
    idle_row(4'd5);
    add_row(4'd5, y86_pkg::I_PUSH, 4'h0, 4'd9, 4'hf, 64'h0, 2'd0);
    idle_row(4'd5);
    add_row(4'd5, y86_pkg::I_POP, 4'h0, 4'd13, 4'hf, 64'h0, 2'd0);
    idle_row(4'd5);
    add_row(4'd5, y86_pkg::I_PUSH, 4'h0, 4'd9, 4'hf, 64'h0, 2'd0);
    idle_row(4'd5);
    add_row(4'd5, y86_pkg::I_POP, 4'h0, 4'd4, 4'hf, 64'h0, 2'd0); // popq rsp
    add_row(4'd6, y86_pkg::I_IRMOV, 4'h0, 4'hf, 4'd0, 64'h1111, 2'd0);
    add_row(4'd6, y86_pkg::I_IRMOV, 4'h0, 4'hf, 4'd1, 64'h2222, 2'd0);
    add_row(4'd6, y86_pkg::I_OPQ, 4'h0, 4'd2, 4'd3, 64'h0, 2'd0);
    add_row(4'd6, y86_pkg::I_CMOV, 4'h0, 4'd5, 4'd6, 64'h0, 2'd0); // rrmovq
    add_row(4'd6, y86_pkg::I_NOP, 4'h0, 4'hf, 4'hf, 64'h0, 2'd0);
    add_row(4'd6, y86_pkg::I_HALT, 4'h0, 4'hf, 4'hf, 64'h0, 2'd0);
  endtask

  initial
  begin
    wait (table_built);
    repeat (rows.size() * 8 + RESET_CYCLES) @(posedge clk);
    $display("watchdog timeout, the tests did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    int err_start;
    arst_n = 1'b0;
    issue = 1'b0;
    icode = 4'h1;
    ifun = 4'h0;
    ra = 4'hf;
    rb = 4'hf;
    valc = '0;
    dbg_addr = '0;
    lfsr = 16'd84;
    last_rnd = '0;
    cyc = 0;
    tests = 0;
    checks = 0;
    errors = 0;
    for (int i = 0; i < 16; i++)
    begin
      m_reg[i] = 64'(i);
      m_mem[i] = '0;
    end
    m_zf = 1'b1;
    m_sf = 1'b0;
    m_of = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    err_start = errors;
    read_back();
    report_test(1, err_start);
    err_start = errors;
    for (int n = 0; n < rows.size(); n++)
    begin
      step(rows[n]);
      if (n == rows.size() - 1 || rows[n + 1].test != rows[n].test)
      begin
        repeat (DRAIN_CYCLES) step('0);
        read_back();
        report_test(rows[n].test, err_start);
        err_start = errors;
      end
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== y86_core.f ====
hdl/y86_pkg.sv
hdl/y86_ifs.sv
hdl/decode_wb.sv
hdl/execute_unit.sv
hdl/mem_wb_unit.sv
hdl/y86_core.sv
tb/y86_core_tb.sv
